// File: source/cam_config.svh
`ifndef CAM_CONFIG_SVH
`define CAM_CONFIG_SVH

// Micro-block size in pixels
`define CAM_BLOCK_W      8
`define CAM_BLOCK_H      16

// Blocks across and down one frame
`define CAM_BLOCK_COLS   5
`define CAM_BLOCK_LINES  3

// Pixel FIFO between capture and statistics
`define CAM_FIFO_DEPTH   16

`endif

// File: source/cam_pkg.sv
`include "cam_config.svh"

package cam_pkg;

    // Coordinate widths follow the frame geometry
    localparam int PIX_COL_W  = $clog2(`CAM_BLOCK_W);
    localparam int PIX_LINE_W = $clog2(`CAM_BLOCK_H);
    localparam int BLK_COL_W  = $clog2(`CAM_BLOCK_COLS);
    localparam int BLK_LINE_W = $clog2(`CAM_BLOCK_LINES);

    // Word from the camera FIFO, blue in the high byte
    typedef struct packed {
        logic [23:0] rgb;
        logic        hsync;
        logic        vsync;
    } cam_in_t;

    // Captured pixel, red high and blue low
    typedef struct packed {
        logic [23:0]           rgb;
        logic [PIX_COL_W-1:0]  pixel_col;
        logic [PIX_LINE_W-1:0] pixel_line;
        logic [BLK_COL_W-1:0]  block_col;
        logic [BLK_LINE_W-1:0] block_line;
    } pix_t;

    // Mean colour of one finished block
    typedef struct packed {
        logic [BLK_COL_W-1:0]  block_col;
        logic [BLK_LINE_W-1:0] block_line;
        logic [23:0]           avg;
    } blk_result_t;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_REQ,
        ST_RELEASE
    } stats_state_e;

endpackage

// File: source/pixel_capture.sv
`timescale 1ns/1ps
`include "cam_config.svh"

module pixel_capture (
    input  logic             clk,
    input  logic             nrst,
    input  cam_pkg::cam_in_t cam_in,
    input  logic             empty,
    input  logic             rgb_enable,
    output logic             push,
    output cam_pkg::pix_t    push_pix
);
    import cam_pkg::*;

    logic                  vsync_q;
    logic                  frame_start;
    logic                  pixel_cycle;
    logic                  enable_q;
    logic [PIX_COL_W-1:0]  pixel_col;
    logic [PIX_LINE_W-1:0] pixel_line;
    logic [BLK_COL_W-1:0]  block_col;
    logic [BLK_LINE_W-1:0] block_line;

    // Rising vsync on a valid word starts a frame and carries no pixel
    assign frame_start = !empty && cam_in.vsync && !vsync_q;
    assign pixel_cycle = !empty && cam_in.vsync && cam_in.hsync && vsync_q;

    // Previous vsync only advanced by valid words
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            vsync_q <= 1'b0;
        end else if (!empty) begin
            vsync_q <= cam_in.vsync;
        end
    end

    // Enable only changes on a frame boundary
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            enable_q <= 1'b0;
        end else if (frame_start) begin
            enable_q <= rgb_enable;
        end
    end

    // Nested counters from pixel column out to block line
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pixel_col  <= '0;
            pixel_line <= '0;
            block_col  <= '0;
            block_line <= '0;
        end else if (frame_start) begin
            pixel_col  <= '0;
            pixel_line <= '0;
            block_col  <= '0;
            block_line <= '0;
        end else if (pixel_cycle) begin
            pixel_col <= pixel_col + 1'b1;
            if (pixel_col == PIX_COL_W'(`CAM_BLOCK_W - 1)) begin
                pixel_col <= '0;
                block_col <= block_col + 1'b1;
                if (block_col == BLK_COL_W'(`CAM_BLOCK_COLS - 1)) begin
                    block_col  <= '0;
                    pixel_line <= pixel_line + 1'b1;
                    if (pixel_line == PIX_LINE_W'(`CAM_BLOCK_H - 1)) begin
                        pixel_line <= '0;
                        block_line <= block_line + 1'b1;
                        if (block_line == BLK_LINE_W'(`CAM_BLOCK_LINES - 1)) begin
                            block_line <= '0;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            push <= 1'b0;
        end else begin
            push <= pixel_cycle && enable_q;
        end
    end

    // Swap BGR to RGB and tag with the coordinates before they advance
    always_ff @(posedge clk) begin
        if (pixel_cycle) begin
            push_pix.rgb        <= {cam_in.rgb[7:0], cam_in.rgb[15:8], cam_in.rgb[23:16]};
            push_pix.pixel_col  <= pixel_col;
            push_pix.pixel_line <= pixel_line;
            push_pix.block_col  <= block_col;
            push_pix.block_line <= block_line;
        end
    end

    // Every pushed pixel lies inside the frame
    a_push_in_frame: assert property (@(posedge clk) disable iff (!nrst)
        push |-> (push_pix.block_col < `CAM_BLOCK_COLS) &&
                 (push_pix.block_line < `CAM_BLOCK_LINES));

endmodule

// File: source/pixel_fifo.sv
`timescale 1ns/1ps
`include "cam_config.svh"

module pixel_fifo #(
    parameter int DEPTH = `CAM_FIFO_DEPTH
) (
    input  logic          clk,
    input  logic          nrst,
    input  logic          push,
    input  cam_pkg::pix_t push_pix,
    input  logic          pop,
    output cam_pkg::pix_t pop_pix,
    output logic          fifo_empty,
    output logic          overflow
);
    import cam_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    pix_t          mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          wr_en;
    logic          rd_en;

    assign full       = (count == CW'(DEPTH));
    assign fifo_empty = (count == '0);
    assign wr_en      = push && !full;
    assign rd_en      = pop && !fifo_empty;
    assign pop_pix    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_pix;
        end
    end

    // Pointers wrap at DEPTH, so any depth works
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Camera cannot wait, a push into a full buffer is lost
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!nrst)
        pop |-> !fifo_empty);

endmodule

// File: source/block_stats.sv
`timescale 1ns/1ps
`include "cam_config.svh"

module block_stats (
    input  logic                 clk,
    input  logic                 nrst,
    input  cam_pkg::pix_t        pop_pix,
    input  logic                 fifo_empty,
    output logic                 pop,
    output logic                 blk_req,
    input  logic                 blk_ack,
    output cam_pkg::blk_result_t blk
);
    import cam_pkg::*;

    // Mean over W*H pixels is a right shift
    localparam int AVG_SHIFT = $clog2(`CAM_BLOCK_W * `CAM_BLOCK_H);
    localparam int SUM_W     = 8 + AVG_SHIFT;

    stats_state_e          state;
    logic [SUM_W-1:0]      sum_r [`CAM_BLOCK_COLS];
    logic [SUM_W-1:0]      sum_g [`CAM_BLOCK_COLS];
    logic [SUM_W-1:0]      sum_b [`CAM_BLOCK_COLS];
    logic                  first_pix;
    logic                  last_pix;
    logic                  done;
    logic [BLK_COL_W-1:0]  done_col;
    logic [BLK_LINE_W-1:0] done_line;

    assign first_pix = (pop_pix.pixel_col == '0) && (pop_pix.pixel_line == '0);
    assign last_pix  = (pop_pix.pixel_col == PIX_COL_W'(`CAM_BLOCK_W - 1)) &&
                       (pop_pix.pixel_line == PIX_LINE_W'(`CAM_BLOCK_H - 1));

    // Hold off while a finished block waits to be offered
    assign pop     = (state == ST_RUN) && !done && !fifo_empty;
    assign blk_req = (state == ST_REQ);

    // One set of channel sums per block column
    always_ff @(posedge clk) begin
        if (pop) begin
            if (first_pix) begin
                sum_r[pop_pix.block_col] <= SUM_W'(pop_pix.rgb[23:16]);
                sum_g[pop_pix.block_col] <= SUM_W'(pop_pix.rgb[15:8]);
                sum_b[pop_pix.block_col] <= SUM_W'(pop_pix.rgb[7:0]);
            end else begin
                sum_r[pop_pix.block_col] <= sum_r[pop_pix.block_col] +
                                            SUM_W'(pop_pix.rgb[23:16]);
                sum_g[pop_pix.block_col] <= sum_g[pop_pix.block_col] +
                                            SUM_W'(pop_pix.rgb[15:8]);
                sum_b[pop_pix.block_col] <= sum_b[pop_pix.block_col] +
                                            SUM_W'(pop_pix.rgb[7:0]);
            end
        end
    end

    // Completion flag goes high the cycle after the last pixel is summed
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            done <= 1'b0;
        end else begin
            done <= pop && last_pix;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && last_pix) begin
            done_col  <= pop_pix.block_col;
            done_line <= pop_pix.block_line;
        end
    end

    // Result payload with the truncated mean per channel
    always_ff @(posedge clk) begin
        if (done) begin
            blk.block_col  <= done_col;
            blk.block_line <= done_line;
            blk.avg        <= {sum_r[done_col][SUM_W-1 -: 8],
                               sum_g[done_col][SUM_W-1 -: 8],
                               sum_b[done_col][SUM_W-1 -: 8]};
        end
    end

    // Four-phase handshake on the result port
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= ST_RUN;
        end else begin
            case (state)
                ST_RUN: begin
                    if (done) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (blk_ack) begin
                        state <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    // Wait for ack to drop before taking more pixels
                    if (!blk_ack) begin
                        state <= ST_RUN;
                    end
                end
                default: state <= ST_RUN;
            endcase
        end
    end

    a_blk_stable: assert property (@(posedge clk) disable iff (!nrst)
        (blk_req && !blk_ack) |=> $stable(blk));

endmodule

// File: source/cam_block_top.sv
`timescale 1ns/1ps
`include "cam_config.svh"

module cam_block_top (
    input  logic                 clk,
    input  logic                 nrst,
    input  cam_pkg::cam_in_t     cam_in,
    input  logic                 empty,
    input  logic                 rgb_enable,
    output logic                 blk_req,
    input  logic                 blk_ack,
    output cam_pkg::blk_result_t blk,
    output logic                 overflow
);
    import cam_pkg::*;

    logic push;
    pix_t push_pix;
    logic pop;
    pix_t pop_pix;
    logic fifo_empty;

    pixel_capture capture_i (
        .clk        (clk),
        .nrst       (nrst),
        .cam_in     (cam_in),
        .empty      (empty),
        .rgb_enable (rgb_enable),
        .push       (push),
        .push_pix   (push_pix)
    );

    // Absorbs pixels while a block result waits for ack
    pixel_fifo #(
        .DEPTH (`CAM_FIFO_DEPTH)
    ) fifo_i (
        .clk        (clk),
        .nrst       (nrst),
        .push       (push),
        .push_pix   (push_pix),
        .pop        (pop),
        .pop_pix    (pop_pix),
        .fifo_empty (fifo_empty),
        .overflow   (overflow)
    );

    block_stats stats_i (
        .clk        (clk),
        .nrst       (nrst),
        .pop_pix    (pop_pix),
        .fifo_empty (fifo_empty),
        .pop        (pop),
        .blk_req    (blk_req),
        .blk_ack    (blk_ack),
        .blk        (blk)
    );

endmodule

// File: test/tb_cam_block.sv
`timescale 1ns/1ps
`include "cam_config.svh"

module tb_cam_block;
    import cam_pkg::*;

    localparam int FRAME_W      = `CAM_BLOCK_W * `CAM_BLOCK_COLS;
    localparam int FRAME_H      = `CAM_BLOCK_H * `CAM_BLOCK_LINES;
    localparam int FRAME_BLOCKS = `CAM_BLOCK_COLS * `CAM_BLOCK_LINES;
    localparam int NUM_ROWS     = 5;
    localparam int WAIT_LIMIT   = 20000;
    localparam int QUIET_CYCLES = 200;
    localparam int MAX_GAP      = 8;

    typedef struct {
        string name;
        logic  enable;
        int    gap_pct;
        int    blank;
        int    ack_delay;
        logic  exp_ovf;
    } row_t;

    logic        clk;
    logic        nrst;
    cam_in_t     cam_in;
    logic        empty;
    logic        rgb_enable;
    logic        blk_req;
    logic        blk_ack;
    blk_result_t blk;
    logic        overflow;

    row_t        table_rows [NUM_ROWS];
    string       cur_name;
    int          cur_gap;
    int          ack_delay;
    logic [31:0] gap_state;
    blk_result_t got_q [$];
    blk_result_t exp_q [$];
    logic [7:0]  red_px   [FRAME_H][FRAME_W];
    logic [7:0]  green_px [FRAME_H][FRAME_W];
    logic [7:0]  blue_px  [FRAME_H][FRAME_W];

    cam_block_top dut_i (
        .clk        (clk),
        .nrst       (nrst),
        .cam_in     (cam_in),
        .empty      (empty),
        .rgb_enable (rgb_enable),
        .blk_req    (blk_req),
        .blk_ack    (blk_ack),
        .blk        (blk),
        .overflow   (overflow)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_blk(input string label, input blk_result_t exp, input blk_result_t act);
        string exp_s;
        string act_s;
        exp_s = $sformatf("col %0d line %0d avg %06h", exp.block_col, exp.block_line, exp.avg);
        act_s = $sformatf("col %0d line %0d avg %06h", act.block_col, act.block_line, act.avg);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %s actual %s", label, exp_s, act_s));
        end
    endtask

    task automatic check_overflow(input string label, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s overflow expected %b actual %b",
                label, exp, act));
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        empty <= 1'b1;
    endtask

    // Camera pixel clock is half the system clock, so each word is followed by an empty cycle
    task automatic send_word(input logic [23:0] bgr, input logic hs, input logic vs);
        cam_in_t w;
        int      n;
        w.rgb   = bgr;
        w.hsync = hs;
        w.vsync = vs;
        n = 0;
        gap_state = xorshift(gap_state);
        while (n < MAX_GAP && int'(gap_state % 100) < cur_gap) begin
            idle_cycle();
            gap_state = xorshift(gap_state);
            n++;
        end
        @(posedge clk);
        cam_in <= w;
        empty  <= 1'b0;
        idle_cycle();
    endtask

    // Mean of each block straight from the stored frame in completion order
    task automatic build_expected();
        int          sr;
        int          sg;
        int          sb;
        blk_result_t e;
        exp_q.delete();
        for (int bl = 0; bl < `CAM_BLOCK_LINES; bl++) begin
            for (int bc = 0; bc < `CAM_BLOCK_COLS; bc++) begin
                sr = 0;
                sg = 0;
                sb = 0;
                for (int y = bl * `CAM_BLOCK_H; y < (bl + 1) * `CAM_BLOCK_H; y++) begin
                    for (int x = bc * `CAM_BLOCK_W; x < (bc + 1) * `CAM_BLOCK_W; x++) begin
                        sr += red_px[y][x];
                        sg += green_px[y][x];
                        sb += blue_px[y][x];
                    end
                end
                e.block_col  = BLK_COL_W'(bc);
                e.block_line = BLK_LINE_W'(bl);
                e.avg = {8'(sr / (`CAM_BLOCK_W * `CAM_BLOCK_H)),
                         8'(sg / (`CAM_BLOCK_W * `CAM_BLOCK_H)),
                         8'(sb / (`CAM_BLOCK_W * `CAM_BLOCK_H))};
                exp_q.push_back(e);
            end
        end
    endtask

    // Same pixel data every frame with blue in the high byte of each word
    task automatic send_frame(input logic en, input int blank);
        logic [31:0] pix_state;
        logic [23:0] bgr;
        pix_state = 32'h4fd3;
        @(posedge clk);
        rgb_enable <= en;
        empty      <= 1'b1;
        send_word(24'h0, 1'b0, 1'b0);
        send_word(24'h0, 1'b0, 1'b1);
        for (int y = 0; y < FRAME_H; y++) begin
            // Late enable must wait for the next frame start
            if (!en && y == FRAME_H / 2) begin
                rgb_enable <= 1'b1;
            end
            for (int k = 0; k < blank; k++) begin
                send_word(24'h0, 1'b0, 1'b1);
            end
            for (int x = 0; x < FRAME_W; x++) begin
                pix_state = xorshift(pix_state);
                bgr = pix_state[23:0];
                blue_px[y][x]  = bgr[23:16];
                green_px[y][x] = bgr[15:8];
                red_px[y][x]   = bgr[7:0];
                send_word(bgr, 1'b1, 1'b1);
            end
        end
        send_word(24'h0, 1'b0, 1'b0);
        build_expected();
    endtask

    task automatic wait_results(input int n);
        int cycles;
        cycles = 0;
        while (got_q.size() < n) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error($sformatf("%s: timed out waiting for %0d block results",
                    cur_name, n));
            end
        end
    endtask

    task automatic wait_quiet(input int n);
        int quiet;
        int cycles;
        quiet = 0;
        cycles = 0;
        while (quiet < n) begin
            @(posedge clk);
            cycles++;
            quiet = (blk_req || blk_ack) ? 0 : quiet + 1;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error($sformatf("%s: result port never went idle", cur_name));
            end
        end
    endtask

    task automatic run_row(input row_t row);
        int exp_n;
        cur_name  = row.name;
        cur_gap   = row.gap_pct;
        ack_delay = row.ack_delay;
        got_q.delete();
        send_frame(row.enable, row.blank);
        exp_n = row.enable ? FRAME_BLOCKS : 0;
        if (!row.exp_ovf && exp_n > 0) begin
            wait_results(exp_n);
        end
        wait_quiet(QUIET_CYCLES);
        check_overflow(row.name, row.exp_ovf, overflow);
        // Dropped pixels make the overflow row's values meaningless
        if (!row.exp_ovf) begin
            if (got_q.size() != exp_n) begin
                stop_on_error($sformatf("MISMATCH %s result count expected %0d actual %0d",
                    row.name, exp_n, got_q.size()));
            end
            for (int i = 0; i < exp_n; i++) begin
                check_blk($sformatf("%s block %0d", row.name, i), exp_q[i], got_q[i]);
            end
        end
    endtask

    // Ack after a programmable delay and release once req drops
    initial begin : ack_responder
        blk_result_t held;
        int          cycles;
        blk_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (nrst && blk_req && !blk_ack) begin
                held = blk;
                got_q.push_back(blk);
                for (int i = 0; i < ack_delay; i++) begin
                    @(posedge clk);
                    if (!blk_req) begin
                        stop_on_error($sformatf("%s: blk_req fell before ack", cur_name));
                    end
                    check_blk($sformatf("%s held result", cur_name), held, blk);
                end
                blk_ack <= 1'b1;
                cycles = 0;
                while (blk_req) begin
                    @(posedge clk);
                    cycles++;
                    if (cycles > WAIT_LIMIT) begin
                        stop_on_error($sformatf("%s: blk_req never fell after ack", cur_name));
                    end
                end
                blk_ack <= 1'b0;
            end
        end
    end

    initial begin : overflow_monitor
        logic seen;
        seen = 1'b0;
        forever begin
            @(posedge clk);
            if (seen && overflow !== 1'b1) begin
                stop_on_error("overflow dropped after it had been set");
            end
            if (overflow === 1'b1) begin
                seen = 1'b1;
            end
        end
    end

    initial begin : main
        nrst       = 1'b0;
        cam_in     = '0;
        empty      = 1'b1;
        rgb_enable = 1'b0;
        gap_state  = 32'h4fd3;
        cur_name   = "reset";
        cur_gap    = 0;
        ack_delay  = 0;
        table_rows[0] = '{"enabled_frame",  1'b1,  0, 1,  0, 1'b0};
        table_rows[1] = '{"disabled_frame", 1'b0,  0, 1,  0, 1'b0};
        table_rows[2] = '{"random_gaps",    1'b1, 30, 6,  0, 1'b0};
        table_rows[3] = '{"slow_ack",       1'b1,  0, 1,  3, 1'b0};
        table_rows[4] = '{"ack_overflow",   1'b1,  0, 1, 60, 1'b1};
        repeat (10) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        check_overflow("reset", 1'b0, overflow);
        if (blk_req !== 1'b0) begin
            stop_on_error("blk_req is not low after reset");
        end
        for (int t = 0; t < NUM_ROWS; t++) begin
            run_row(table_rows[t]);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// File: src.f
+incdir+source
source/cam_pkg.sv
source/pixel_capture.sv
source/pixel_fifo.sv
source/block_stats.sv
source/cam_block_top.sv
test/tb_cam_block.sv

// File: Makefile
TOP := tb_cam_block

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP)

# Pass only when the testbench prints its pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
